// File: include/dual_issue_cfg.svh
`ifndef DUAL_ISSUE_CFG_SVH
`define DUAL_ISSUE_CFG_SVH

// instruction queue entries
// must stay a power of two, the pointers wrap on their own
`define DI_QUEUE_DEPTH 8

// issue lanes, lane 0 always holds the older instruction
`define DI_NUM_LANES 2

// datapath width
`define DI_XLEN 32

// architectural registers
`define DI_NUM_REGS 32

`endif

// File: verilog/isa_pkg.sv
`include "dual_issue_cfg.svh"

package isa_pkg;

    typedef logic [`DI_XLEN-1:0]              word_t;
    typedef logic [$clog2(`DI_NUM_REGS)-1:0]  reg_addr_t;
    typedef logic [4:0]                       shamt_t;
    typedef logic [15:0]                      imm_t;

    // major opcodes of the kept subset
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f
    } opcode_e;

    // function field of R-type words
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        // operand b passed as is
        ALU_LUI
    } alu_op_e;

endpackage

// File: verilog/pipe_pkg.sv
`include "dual_issue_cfg.svh"

package pipe_pkg;

    import isa_pkg::*;

    // one lane's worth of work, operands already resolved
    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        word_t     op_a;
        word_t     op_b;
        shamt_t    shamt;
        logic      we;
        reg_addr_t dest;
    } issue_pkt_t;

    // result report, valid only for instructions that write a register
    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        word_t     data;
    } wb_pkt_t;

    typedef wb_pkt_t [`DI_NUM_LANES-1:0] wb_vec_t;

    // two oldest queue words, index 0 is the oldest
    typedef word_t [1:0] q_word_t;

    // queue occupancy, 0 up to full
    typedef logic [$clog2(`DI_QUEUE_DEPTH + 1)-1:0] q_count_t;

endpackage

// File: verilog/inst_queue.sv
`timescale 1ns/1ps
`include "dual_issue_cfg.svh"

module inst_queue (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               wr1_i,
    input  logic               wr2_i,
    input  isa_pkg::word_t     wdata1_i,
    input  isa_pkg::word_t     wdata2_i,
    input  logic [1:0]         pop_i,
    output pipe_pkg::q_word_t  heads_o,
    output pipe_pkg::q_count_t count_o,
    output logic               room_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int PTR_W = $clog2(`DI_QUEUE_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;

    word_t    mem [`DI_QUEUE_DEPTH];
    ptr_t     wr_ptr;
    ptr_t     wr_ptr_nx;
    ptr_t     rd_ptr;
    ptr_t     rd_ptr_nx;
    q_count_t count_q;
    logic     wr_second;
    logic [1:0] n_wr;

    // second word only counts together with the first
    assign wr_second = wr1_i && wr2_i;
    assign n_wr      = {1'b0, wr1_i} + {1'b0, wr_second};

    assign wr_ptr_nx = wr_ptr + 1'b1;
    assign rd_ptr_nx = rd_ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (wr1_i) begin
            mem[wr_ptr] <= wdata1_i;
        end
        if (wr_second) begin
            mem[wr_ptr_nx] <= wdata2_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            wr_ptr  <= wr_ptr + ptr_t'(n_wr);
            rd_ptr  <= rd_ptr + ptr_t'(pop_i);
            count_q <= count_q + q_count_t'(n_wr) - q_count_t'(pop_i);
        end
    end

    // slot 1 may hold stale data, issue checks the count
    assign heads_o[0] = mem[rd_ptr];
    assign heads_o[1] = mem[rd_ptr_nx];
    assign count_o    = count_q;

    // room for a full two-word fetch
    assign room_o = count_q <= q_count_t'(`DI_QUEUE_DEPTH - 2);

endmodule

// File: verilog/issue_ctrl.sv
`timescale 1ns/1ps
`include "dual_issue_cfg.svh"

module issue_ctrl (
    input  pipe_pkg::q_word_t                           heads_i,
    input  pipe_pkg::q_count_t                          count_i,
    input  pipe_pkg::wb_vec_t                           ex_i,
    input  pipe_pkg::wb_vec_t                           wb_i,
    input  isa_pkg::word_t     [2*`DI_NUM_LANES-1:0]    rs_data_i,
    output isa_pkg::reg_addr_t [2*`DI_NUM_LANES-1:0]    rs_addr_o,
    output pipe_pkg::issue_pkt_t [`DI_NUM_LANES-1:0]    pkt_o,
    output logic [1:0]                                  pop_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    typedef struct packed {
        alu_op_e   alu_op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
        shamt_t    shamt;
        word_t     imm_ext;
        logic      use_rs;
        logic      use_rt;
        logic      use_imm;
        logic      we;
    } dec_t;

    dec_t [`DI_NUM_LANES-1:0] dec;
    logic [`DI_NUM_LANES-1:0] issue;
    logic                     pair_hazard;

    function automatic dec_t decode(input word_t w);
        dec_t d;
        imm_t imm;
        d        = '0;
        imm      = w[15:0];
        d.rs     = w[25:21];
        d.rt     = w[20:16];
        d.alu_op = ALU_ADD;
        if (opcode_e'(w[31:26]) == OP_RTYPE) begin
            d.dest   = w[15:11];
            d.use_rs = 1'b1;
            d.use_rt = 1'b1;
            d.we     = 1'b1;
            case (funct_e'(w[5:0]))
                FN_ADDU: d.alu_op = ALU_ADD;
                FN_SUBU: d.alu_op = ALU_SUB;
                FN_AND:  d.alu_op = ALU_AND;
                FN_OR:   d.alu_op = ALU_OR;
                FN_XOR:  d.alu_op = ALU_XOR;
                FN_NOR:  d.alu_op = ALU_NOR;
                FN_SLT:  d.alu_op = ALU_SLT;
                FN_SLTU: d.alu_op = ALU_SLTU;
                FN_SLL:  d.alu_op = ALU_SLL;
                FN_SRL:  d.alu_op = ALU_SRL;
                FN_SRA:  d.alu_op = ALU_SRA;
                default: d.we = 1'b0;
            endcase
            // shifts take rt and the shamt field only
            if (d.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA}) begin
                d.use_rs = 1'b0;
                d.shamt  = w[10:6];
            end
        end else begin
            d.dest    = w[20:16];
            d.use_rs  = 1'b1;
            d.use_imm = 1'b1;
            d.we      = 1'b1;
            d.imm_ext = word_t'($signed(imm));
            case (opcode_e'(w[31:26]))
                OP_ADDIU: d.alu_op = ALU_ADD;
                OP_SLTI:  d.alu_op = ALU_SLT;
                OP_ANDI: begin
                    d.alu_op  = ALU_AND;
                    d.imm_ext = word_t'(imm);
                end
                OP_ORI: begin
                    d.alu_op  = ALU_OR;
                    d.imm_ext = word_t'(imm);
                end
                OP_XORI: begin
                    d.alu_op  = ALU_XOR;
                    d.imm_ext = word_t'(imm);
                end
                OP_LUI: begin
                    d.alu_op  = ALU_LUI;
                    d.use_rs  = 1'b0;
                    d.imm_ext = {imm, 16'h0000};
                end
                default: begin
                    d.we     = 1'b0;
                    d.use_rs = 1'b0;
                end
            endcase
        end
        // writes to r0 vanish here
        if (d.dest == '0) begin
            d.we = 1'b0;
        end
        return d;
    endfunction

    // later assignments win: ex lane 1 is the youngest result in flight
    function automatic word_t fwd(input reg_addr_t a, input word_t rf,
                                  input wb_vec_t ex, input wb_vec_t wb);
        word_t v;
        v = rf;
        for (int i = 0; i < `DI_NUM_LANES; i++) begin
            if (wb[i].valid && wb[i].dest == a) begin
                v = wb[i].data;
            end
        end
        for (int i = 0; i < `DI_NUM_LANES; i++) begin
            if (ex[i].valid && ex[i].dest == a) begin
                v = ex[i].data;
            end
        end
        if (a == '0) begin
            v = '0;
        end
        return v;
    endfunction

    assign dec[0] = decode(heads_i[0]);
    assign dec[1] = decode(heads_i[1]);

    // second word must not depend on the first
    assign pair_hazard = dec[0].we &&
                         ((dec[1].use_rs && dec[1].rs == dec[0].dest) ||
                          (dec[1].use_rt && dec[1].rt == dec[0].dest));

    assign issue[0] = count_i != '0;
    assign issue[1] = (count_i >= q_count_t'(2)) && !pair_hazard;

    assign pop_o = {1'b0, issue[0]} + {1'b0, issue[1]};

    always_comb begin
        for (int l = 0; l < `DI_NUM_LANES; l++) begin
            rs_addr_o[2*l]     = dec[l].rs;
            rs_addr_o[2*l + 1] = dec[l].rt;
            pkt_o[l].valid     = issue[l];
            pkt_o[l].alu_op    = dec[l].alu_op;
            pkt_o[l].op_a      = dec[l].use_rs ?
                                 fwd(dec[l].rs, rs_data_i[2*l], ex_i, wb_i) : '0;
            pkt_o[l].op_b      = dec[l].use_imm ? dec[l].imm_ext :
                                 fwd(dec[l].rt, rs_data_i[2*l + 1], ex_i, wb_i);
            pkt_o[l].shamt     = dec[l].shamt;
            pkt_o[l].we        = dec[l].we;
            pkt_o[l].dest      = dec[l].dest;
        end
    end

endmodule

// File: verilog/exec_lane.sv
`timescale 1ns/1ps

module exec_lane (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  pipe_pkg::issue_pkt_t pkt_i,
    output pipe_pkg::wb_pkt_t    ex_o,
    output pipe_pkg::wb_pkt_t    wb_o
);

    import isa_pkg::*;

    // execute stage
    logic      ex_vld;
    alu_op_e   ex_op;
    word_t     ex_a;
    word_t     ex_b;
    shamt_t    ex_shamt;
    reg_addr_t ex_dest;
    word_t     alu_res;

    // write-back stage
    logic      wb_vld;
    reg_addr_t wb_dest;
    word_t     wb_data;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_vld <= 1'b0;
            wb_vld <= 1'b0;
        end else begin
            // only writers produce a report
            ex_vld <= pkt_i.valid && pkt_i.we;
            wb_vld <= ex_vld;
        end
    end

    always_ff @(posedge clk) begin
        ex_op    <= pkt_i.alu_op;
        ex_a     <= pkt_i.op_a;
        ex_b     <= pkt_i.op_b;
        ex_shamt <= pkt_i.shamt;
        ex_dest  <= pkt_i.dest;
        wb_dest  <= ex_dest;
        wb_data  <= alu_res;
    end

    always_comb begin
        case (ex_op)
            ALU_ADD:  alu_res = ex_a + ex_b;
            ALU_SUB:  alu_res = ex_a - ex_b;
            ALU_AND:  alu_res = ex_a & ex_b;
            ALU_OR:   alu_res = ex_a | ex_b;
            ALU_XOR:  alu_res = ex_a ^ ex_b;
            ALU_NOR:  alu_res = ~(ex_a | ex_b);
            ALU_SLT:  alu_res = word_t'($signed(ex_a) < $signed(ex_b));
            ALU_SLTU: alu_res = word_t'(ex_a < ex_b);
            // shifts act on rt, carried in operand b
            ALU_SLL:  alu_res = ex_b << ex_shamt;
            ALU_SRL:  alu_res = ex_b >> ex_shamt;
            ALU_SRA:  alu_res = word_t'($signed(ex_b) >>> ex_shamt);
            ALU_LUI:  alu_res = ex_b;
            default:  alu_res = '0;
        endcase
    end

    assign ex_o = '{valid: ex_vld, dest: ex_dest, data: alu_res};
    assign wb_o = '{valid: wb_vld, dest: wb_dest, data: wb_data};

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`include "dual_issue_cfg.svh"

module reg_file (
    input  logic                                     clk,
    input  logic                                     arst_n_i,
    input  pipe_pkg::wb_vec_t                        wb_i,
    input  isa_pkg::reg_addr_t [2*`DI_NUM_LANES-1:0] raddr_i,
    output isa_pkg::word_t     [2*`DI_NUM_LANES-1:0] rdata_o
);

    import isa_pkg::*;

    word_t regs [`DI_NUM_REGS];

    // higher lane written last, so lane 1 wins a shared destination
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 0; r < `DI_NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < `DI_NUM_LANES; l++) begin
                if (wb_i[l].valid && wb_i[l].dest != '0) begin
                    regs[wb_i[l].dest] <= wb_i[l].data;
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2*`DI_NUM_LANES; p++) begin
            rdata_o[p] = (raddr_i[p] == '0) ? '0 : regs[raddr_i[p]];
        end
    end

endmodule

// File: verilog/dual_issue_top.sv
`timescale 1ns/1ps
`include "dual_issue_cfg.svh"

module dual_issue_top (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              inst_ok1_i,
    input  logic              inst_ok2_i,
    input  isa_pkg::word_t    inst_rdata1_i,
    input  isa_pkg::word_t    inst_rdata2_i,
    output logic              fetch_en_o,
    output pipe_pkg::wb_vec_t wb_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    q_word_t                       heads;
    q_count_t                      count;
    logic [1:0]                    pop;
    wb_vec_t                       ex_vec;
    issue_pkt_t [`DI_NUM_LANES-1:0] pkt;
    reg_addr_t  [2*`DI_NUM_LANES-1:0] rs_addr;
    word_t      [2*`DI_NUM_LANES-1:0] rs_data;

    inst_queue u_inst_queue (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wr1_i    (inst_ok1_i),
        .wr2_i    (inst_ok2_i),
        .wdata1_i (inst_rdata1_i),
        .wdata2_i (inst_rdata2_i),
        .pop_i    (pop),
        .heads_o  (heads),
        .count_o  (count),
        .room_o   (fetch_en_o)
    );

    issue_ctrl u_issue_ctrl (
        .heads_i   (heads),
        .count_i   (count),
        .ex_i      (ex_vec),
        .wb_i      (wb_o),
        .rs_data_i (rs_data),
        .rs_addr_o (rs_addr),
        .pkt_o     (pkt),
        .pop_o     (pop)
    );

    for (genvar g = 0; g < `DI_NUM_LANES; g++) begin : g_lane
        exec_lane u_exec_lane (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .pkt_i    (pkt[g]),
            .ex_o     (ex_vec[g]),
            .wb_o     (wb_o[g])
        );
    end

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_i     (wb_o),
        .raddr_i  (rs_addr),
        .rdata_o  (rs_data)
    );

endmodule

// File: bench/tb_dual_issue.sv
`timescale 1ns/1ps
`include "dual_issue_cfg.svh"

module tb_dual_issue;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int DRIVE_DLY  = 2;
    localparam int N_DIRECTED = 21;
    localparam int N_PAIRS    = 24;
    localparam int N_CHAIN    = 120;
    localparam int N_BURST    = 40;
    localparam int N_PUSH     = N_DIRECTED + 2*N_PAIRS + N_CHAIN + 2*N_BURST;

    // expected report and the sources its instruction reads
    typedef struct packed {
        reg_addr_t dest;
        word_t     data;
        logic      rs_used;
        reg_addr_t rs;
        logic      rt_used;
        reg_addr_t rt;
    } exp_t;

    logic      clk;
    logic      arst_n;
    logic      inst_ok1;
    logic      inst_ok2;
    word_t     inst_rdata1;
    word_t     inst_rdata2;
    logic      fetch_en;
    wb_vec_t   wb;

    word_t     model_regs [`DI_NUM_REGS];
    exp_t      exp_q [$];
    integer    seed = 86281;
    reg_addr_t last_dest;
    int        n_pushed;
    int        dual_cnt;

    dual_issue_top u_dut (
        .clk           (clk),
        .arst_n_i      (arst_n),
        .inst_ok1_i    (inst_ok1),
        .inst_ok2_i    (inst_ok2),
        .inst_rdata1_i (inst_rdata1),
        .inst_rdata2_i (inst_rdata2),
        .fetch_en_o    (fetch_en),
        .wb_o          (wb)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        report_failure($sformatf("error at %0t ns: %s expected %h, got %h",
                                 $time, name, exp, act));
    endtask

    function automatic word_t r_type(input logic [5:0] fn, input reg_addr_t rs,
                                     input reg_addr_t rt, input reg_addr_t rd,
                                     input shamt_t sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rs,
                                     input reg_addr_t rt, input imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    // reference model runs each word in program order as it is pushed
    function automatic void model_exec(input word_t w);
        exp_t  e;
        word_t a;
        word_t b;
        word_t sx;
        word_t zx;
        word_t res;
        logic  writes;
        a         = model_regs[w[25:21]];
        b         = model_regs[w[20:16]];
        sx        = {{16{w[15]}}, w[15:0]};
        zx        = {16'h0000, w[15:0]};
        res       = '0;
        writes    = 1'b1;
        e         = '0;
        e.rs      = w[25:21];
        e.rt      = w[20:16];
        e.rs_used = 1'b1;
        if (w[31:26] == OP_RTYPE) begin
            e.dest    = w[15:11];
            e.rt_used = 1'b1;
            case (w[5:0])
                FN_ADDU: res = a + b;
                FN_SUBU: res = a - b;
                FN_AND:  res = a & b;
                FN_OR:   res = a | b;
                FN_XOR:  res = a ^ b;
                FN_NOR:  res = ~(a | b);
                FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                FN_SLTU: res = {31'd0, a < b};
                FN_SLL:  res = b << w[10:6];
                FN_SRL:  res = b >> w[10:6];
                FN_SRA:  res = $signed(b) >>> w[10:6];
                default: writes = 1'b0;
            endcase
            // shift amount comes from the word
            if (w[5:0] inside {FN_SLL, FN_SRL, FN_SRA}) begin
                e.rs_used = 1'b0;
            end
        end else begin
            e.dest = w[20:16];
            case (w[31:26])
                OP_ADDIU: res = a + sx;
                OP_SLTI:  res = {31'd0, $signed(a) < $signed(sx)};
                OP_ANDI:  res = a & zx;
                OP_ORI:   res = a | zx;
                OP_XORI:  res = a ^ zx;
                OP_LUI:   res = {w[15:0], 16'h0000};
                default:  writes = 1'b0;
            endcase
            e.rs_used = w[31:26] != OP_LUI;
        end
        if (writes && e.dest != '0) begin
            model_regs[e.dest] = res;
            e.data             = res;
            exp_q.push_back(e);
        end
    endfunction

    function automatic word_t rand_inst();
        logic [31:0] r;
        reg_addr_t   a;
        reg_addr_t   b;
        reg_addr_t   d;
        r = $random(seed);
        // sources often take the last destination so chains form
        a = r[0] ? last_dest : {2'b00, r[3:1]};
        b = r[4] ? last_dest : {2'b00, r[7:5]};
        d = {2'b00, r[11:9]};
        last_dest = d;
        // funct ranges 0x00 to 0x0f and 0x20 to 0x2f and opcodes 0x08 to 0x0f include no-ops
        if (r[8]) begin
            return {6'h00, a, b, d, r[16:12], r[18], 1'b0, r[22:19]};
        end
        return {3'b001, r[14:12], a, d, r[31:16]};
    endfunction

    task automatic push_words(input int n, input word_t w1, input word_t w2);
        while (!fetch_en) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        inst_ok1    = 1'b1;
        inst_ok2    = n == 2;
        inst_rdata1 = w1;
        inst_rdata2 = w2;
        model_exec(w1);
        if (n == 2) begin
            model_exec(w2);
        end
        n_pushed += n;
        @(posedge clk);
        #DRIVE_DLY;
        inst_ok1 = 1'b0;
        inst_ok2 = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            wait_cycles(1);
        end
        // catch stray reports
        wait_cycles(10);
    endtask

    task automatic check_report(input int lane, input wb_pkt_t got, output exp_t e);
        assert (exp_q.size() != 0)
        else report_failure($sformatf("lane %0d reported with no result outstanding", lane));
        e = exp_q.pop_front();
        assert (got.dest == e.dest)
        else report_mismatch($sformatf("wb_o[%0d].dest", lane),
                             word_t'(e.dest), word_t'(got.dest));
        assert (got.data == e.data)
        else report_mismatch($sformatf("wb_o[%0d].data", lane), e.data, got.data);
    endtask

    always @(negedge clk) begin
        exp_t e0;
        exp_t e1;
        if (n_pushed == 0) begin
            assert (!wb[0].valid && !wb[1].valid && fetch_en)
            else report_failure("report or low fetch enable before the first push");
        end
        if (wb[0].valid) begin
            check_report(0, wb[0], e0);
        end
        if (wb[1].valid) begin
            check_report(1, wb[1], e1);
        end
        // a same-cycle pair never holds a dependent second word
        if (wb[0].valid && wb[1].valid) begin
            dual_cnt++;
            assert (!(e1.rs_used && e1.rs == e0.dest) && !(e1.rt_used && e1.rt == e0.dest))
            else report_failure("lane 1 read the destination of lane 0 issued with it");
        end
    end

    initial begin
        #(CLK_PERIOD * (12 * N_PUSH + 100));
        report_failure("watchdog expired before all reports drained");
    end

    initial begin
        word_t       w1;
        word_t       w2;
        logic [31:0] rnd;
        clk         = 1'b0;
        arst_n      = 1'b0;
        inst_ok1    = 1'b0;
        inst_ok2    = 1'b0;
        inst_rdata1 = '0;
        inst_rdata2 = '0;
        last_dest   = '0;
        model_regs  = '{default: '0};
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        wait_cycles(4);

        // every kept operation with one word per strobe
        push_words(1, i_type(OP_LUI, 5'd0, 5'd1, 16'h8765), '0);
        push_words(1, i_type(OP_ORI, 5'd1, 5'd1, 16'h4321), '0);
        push_words(1, i_type(OP_ADDIU, 5'd0, 5'd2, 16'hfffb), '0);
        push_words(1, i_type(OP_ANDI, 5'd1, 5'd3, 16'hff0f), '0);
        push_words(1, i_type(OP_ORI, 5'd0, 5'd4, 16'h8000), '0);
        push_words(1, i_type(OP_XORI, 5'd1, 5'd5, 16'hffff), '0);
        push_words(1, i_type(OP_SLTI, 5'd2, 5'd6, 16'hfffd), '0);
        push_words(1, i_type(OP_SLTI, 5'd1, 5'd7, 16'h0001), '0);
        push_words(1, r_type(FN_ADDU, 5'd1, 5'd2, 5'd8, 5'd0), '0);
        push_words(1, r_type(FN_SUBU, 5'd2, 5'd1, 5'd9, 5'd0), '0);
        push_words(1, r_type(FN_AND, 5'd1, 5'd5, 5'd10, 5'd0), '0);
        push_words(1, r_type(FN_OR, 5'd3, 5'd4, 5'd11, 5'd0), '0);
        push_words(1, r_type(FN_XOR, 5'd1, 5'd4, 5'd12, 5'd0), '0);
        push_words(1, r_type(FN_NOR, 5'd1, 5'd2, 5'd13, 5'd0), '0);
        push_words(1, r_type(FN_SLT, 5'd1, 5'd4, 5'd14, 5'd0), '0);
        push_words(1, r_type(FN_SLTU, 5'd1, 5'd4, 5'd15, 5'd0), '0);
        push_words(1, r_type(FN_SLL, 5'd0, 5'd1, 5'd16, 5'd4), '0);
        push_words(1, r_type(FN_SRL, 5'd0, 5'd1, 5'd17, 5'd8), '0);
        push_words(1, r_type(FN_SRA, 5'd0, 5'd1, 5'd18, 5'd8), '0);
        push_words(1, i_type(OP_LUI, 5'd0, 5'd19, 16'hffff), '0);
        push_words(1, i_type(OP_ADDIU, 5'd1, 5'd0, 16'h0005), '0);
        drain();

        // sources r1 to r8 and destinations r20 to r30 never overlap
        for (int i = 0; i < N_PAIRS; i++) begin
            rnd = $random(seed);
            w1  = i_type(OP_ADDIU, 5'd1 + {2'b00, rnd[2:0]}, 5'd20 + 5'(i % 6), rnd[31:16]);
            w2  = r_type(FN_SUBU, 5'd1 + {2'b00, rnd[5:3]}, 5'd1 + {2'b00, rnd[8:6]},
                         5'd26 + 5'(i % 5), 5'd0);
            push_words(2, w1, w2);
        end
        drain();
        assert (dual_cnt > 0)
        else report_failure("independent pair stream ended without a dual-lane cycle");

        // dependent chains with gaps that move the producer into write-back or the register file
        for (int i = 0; i < N_CHAIN / 2; i++) begin
            rnd = $random(seed);
            w1  = rand_inst();
            w2  = rand_inst();
            if (rnd[0]) begin
                push_words(2, w1, w2);
            end else begin
                push_words(1, w1, '0);
                push_words(1, w2, '0);
            end
            if (rnd[2:1] == 2'b00) begin
                wait_cycles(1 + int'(rnd[3]));
            end
        end
        drain();

        // back-to-back two-word pushes against fetch_en
        for (int i = 0; i < N_BURST; i++) begin
            w1 = rand_inst();
            w2 = rand_inst();
            push_words(2, w1, w2);
        end
        drain();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/inst_queue.sv
verilog/issue_ctrl.sv
verilog/exec_lane.sv
verilog/reg_file.sv
verilog/dual_issue_top.sv
bench/tb_dual_issue.sv

// File: run.sh
#!/bin/sh
# build and run the dual-issue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_dual_issue -Mdir obj_dir

./obj_dir/Vtb_dual_issue | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
